// File: rtl/soc_lite_pkg.sv
`default_nettype none

package soc_lite_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------
  localparam logic [ADDR_W-1:0] ROM_BASE   = 32'h0001_0000;
  localparam int unsigned       ROM_WORDS  = 16;
  localparam int unsigned       ROM_IDX_W  = 4;
  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] CLINT_LEN  = 32'h0001_0000;

  // clint register offsets, relative to CLINT_BASE
  localparam int unsigned            CLINT_OFS_W     = 16;
  localparam logic [CLINT_OFS_W-1:0] MSIP_OFS        = 16'h0000;
  localparam logic [CLINT_OFS_W-1:0] MTIMECMP_LO_OFS = 16'h4000;
  localparam logic [CLINT_OFS_W-1:0] MTIMECMP_HI_OFS = 16'h4004;
  localparam logic [CLINT_OFS_W-1:0] MTIME_LO_OFS    = 16'hBFF8;
  localparam logic [CLINT_OFS_W-1:0] MTIME_HI_OFS    = 16'hBFFC;
  localparam int unsigned            MTIME_W         = 64;

  // debug hold-off after reset
  localparam int unsigned DBG_DELAY_CYCLES = 50;
  localparam int unsigned DBG_CNT_W        = $clog2(DBG_DELAY_CYCLES + 1);

  // ----------------------------------------------------------
  // bus types
  // ----------------------------------------------------------
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_ROM,
    SEL_CLINT
  } slv_sel_e;

endpackage

`default_nettype wire

// File: rtl/soc_lite_bus_demux.sv
`timescale 1ns/1ps
`default_nettype none

module soc_lite_bus_demux
  import soc_lite_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  bus_req_t               req_i,
  output bus_rsp_t               rsp_o,
  output logic                   rom_req_o,
  output logic [ROM_IDX_W-1:0]   rom_idx_o,
  input  logic [DATA_W-1:0]      rom_rdata_i,
  output logic                   clint_req_o,
  output logic                   clint_we_o,
  output logic [CLINT_OFS_W-1:0] clint_ofs_o,
  output logic [DATA_W-1:0]      clint_wdata_o,
  input  logic [DATA_W-1:0]      clint_rdata_i
);

  logic     rom_hit;
  logic     clint_hit;
  slv_sel_e sel_d;
  logic     err_d;
  logic     valid_q;
  slv_sel_e sel_q;
  logic     err_q;

  // ----------------------------------------------------------
  // address decode
  // ----------------------------------------------------------
  assign rom_hit   = (req_i.addr >= ROM_BASE) &&
                     (req_i.addr < ROM_BASE + 4 * ROM_WORDS);
  assign clint_hit = (req_i.addr >= CLINT_BASE) &&
                     (req_i.addr < CLINT_BASE + CLINT_LEN);

  // rom is read only, a write there is an error
  always_comb begin
    sel_d = SEL_NONE;
    err_d = 1'b1;
    if (rom_hit && !req_i.we) begin
      sel_d = SEL_ROM;
      err_d = 1'b0;
    end else if (clint_hit) begin
      sel_d = SEL_CLINT;
      err_d = 1'b0;
    end
  end

  assign rom_req_o     = req_i.valid && (sel_d == SEL_ROM);
  assign rom_idx_o     = req_i.addr[ROM_IDX_W+1:2];
  assign clint_req_o   = req_i.valid && (sel_d == SEL_CLINT);
  assign clint_we_o    = req_i.we;
  assign clint_ofs_o   = req_i.addr[CLINT_OFS_W-1:0];
  assign clint_wdata_o = req_i.wdata;

  // ----------------------------------------------------------
  // response, one cycle after the request
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      sel_q   <= SEL_NONE;
      err_q   <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      sel_q   <= req_i.valid ? sel_d : SEL_NONE;
      err_q   <= req_i.valid & err_d;
    end
  end

  always_comb begin
    rsp_o.valid = valid_q;
    rsp_o.err   = err_q;
    case (sel_q)
      SEL_ROM:   rsp_o.rdata = rom_rdata_i;
      SEL_CLINT: rsp_o.rdata = clint_rdata_i;
      // no slave selected, error or idle
      default:   rsp_o.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/soc_lite_bootrom.sv
`timescale 1ns/1ps
`default_nettype none

module soc_lite_bootrom
  import soc_lite_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rom_req_i,
  input  logic [ROM_IDX_W-1:0] rom_idx_i,
  output logic [DATA_W-1:0]    rom_rdata_o
);

  logic [DATA_W-1:0] mem [ROM_WORDS];

  // boot image, one hex word per line
  initial begin
    $readmemh("rtl/soc_lite_bootrom.mem", mem);
  end

  // word comes back on the cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (rom_req_i) begin
      rom_rdata_o <= mem[rom_idx_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/soc_lite_clint.sv
`timescale 1ns/1ps
`default_nettype none

module soc_lite_clint
  import soc_lite_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   rtc_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [CLINT_OFS_W-1:0] ofs_i,
  input  logic [DATA_W-1:0]      wdata_i,
  output logic [DATA_W-1:0]      rdata_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  logic [1:0]         rtc_sync_q;
  logic               rtc_prev_q;
  logic               rtc_rise;
  logic               rtc_half_q;
  logic               half_prev_q;
  logic               tick;
  logic               wr_en;
  logic [MTIME_W-1:0] mtime_q;
  logic [MTIME_W-1:0] mtimecmp_q;
  logic [DATA_W-1:0]  msip_q;
  logic [DATA_W-1:0]  rdata_d;
  logic               timer_irq_q;

  // ----------------------------------------------------------
  // rtc sync and divide by two
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q  <= '0;
      rtc_prev_q  <= 1'b0;
      rtc_half_q  <= 1'b0;
      half_prev_q <= 1'b0;
    end else begin
      rtc_sync_q  <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q  <= rtc_sync_q[1];
      half_prev_q <= rtc_half_q;
      if (rtc_rise) begin
        rtc_half_q <= ~rtc_half_q;
      end
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;
  // one mtime step per rising edge of the halved rtc
  assign tick     = rtc_half_q & ~half_prev_q;

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------
  assign wr_en = req_i & we_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= '0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (wr_en && (ofs_i == MSIP_OFS)) begin
        msip_q <= wdata_i;
      end
      if (wr_en && (ofs_i == MTIMECMP_LO_OFS)) begin
        mtimecmp_q[DATA_W-1:0] <= wdata_i;
      end
      if (wr_en && (ofs_i == MTIMECMP_HI_OFS)) begin
        mtimecmp_q[MTIME_W-1:DATA_W] <= wdata_i;
      end
      // bus write wins over the tick
      if (wr_en && (ofs_i == MTIME_LO_OFS)) begin
        mtime_q[DATA_W-1:0] <= wdata_i;
      end else if (wr_en && (ofs_i == MTIME_HI_OFS)) begin
        mtime_q[MTIME_W-1:DATA_W] <= wdata_i;
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // unmapped offsets read as zero
  always_comb begin
    case (ofs_i)
      MSIP_OFS:        rdata_d = msip_q;
      MTIMECMP_LO_OFS: rdata_d = mtimecmp_q[DATA_W-1:0];
      MTIMECMP_HI_OFS: rdata_d = mtimecmp_q[MTIME_W-1:DATA_W];
      MTIME_LO_OFS:    rdata_d = mtime_q[DATA_W-1:0];
      MTIME_HI_OFS:    rdata_d = mtime_q[MTIME_W-1:DATA_W];
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

  // ----------------------------------------------------------
  // interrupts
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_q <= 1'b0;
    end else begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q[0];

endmodule

`default_nettype wire

// File: rtl/soc_lite_debug_gate.sv
`timescale 1ns/1ps
`default_nettype none

module soc_lite_debug_gate
  import soc_lite_pkg::*;
(
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [DBG_CNT_W-1:0] cnt_q;
  logic                 window_done;

  // lets the boot code run before a debug request can stop the core
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DBG_CNT_W'(DBG_DELAY_CYCLES);
    end else if (!window_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign window_done = (cnt_q == '0);
  assign debug_req_o = window_done & debug_req_i;

endmodule

`default_nettype wire

// File: rtl/soc_lite_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_lite_top
  import soc_lite_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     rtc_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  input  logic     debug_req_i,
  output logic     debug_req_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic                   rom_req;
  logic [ROM_IDX_W-1:0]   rom_idx;
  logic [DATA_W-1:0]      rom_rdata;
  logic                   clint_req;
  logic                   clint_we;
  logic [CLINT_OFS_W-1:0] clint_ofs;
  logic [DATA_W-1:0]      clint_wdata;
  logic [DATA_W-1:0]      clint_rdata;

  // ----------------------------------------------------------
  // bus decode
  // ----------------------------------------------------------
  soc_lite_bus_demux i_bus_demux (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( bus_req_i   ),
    .rsp_o         ( bus_rsp_o   ),
    .rom_req_o     ( rom_req     ),
    .rom_idx_o     ( rom_idx     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_req_o   ( clint_req   ),
    .clint_we_o    ( clint_we    ),
    .clint_ofs_o   ( clint_ofs   ),
    .clint_wdata_o ( clint_wdata ),
    .clint_rdata_i ( clint_rdata )
  );

  // ----------------------------------------------------------
  // slaves
  // ----------------------------------------------------------
  soc_lite_bootrom i_bootrom (
    .clk_i       ( clk_i     ),
    .rom_req_i   ( rom_req   ),
    .rom_idx_i   ( rom_idx   ),
    .rom_rdata_o ( rom_rdata )
  );

  soc_lite_clint i_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( clint_we    ),
    .ofs_i       ( clint_ofs   ),
    .wdata_i     ( clint_wdata ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // debug request hold-off
  soc_lite_debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

// File: sim/soc_lite_assert.sv
`timescale 1ns/1ps
`default_nettype none

module soc_lite_assert
  import soc_lite_pkg::*;
(
  input logic     clk_i,
  input logic     ndmreset_n,
  input bus_req_t req_i,
  input bus_rsp_t rsp_i,
  input logic     gated_debug_req_i
);

  int unsigned cycles_q;
  // number of failed assertions
  int unsigned fail_count;

  // cycles since reset release saturate at the window length
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cycles_q <= 0;
    end else if (cycles_q < DBG_DELAY_CYCLES) begin
      cycles_q <= cycles_q + 1;
    end
  end

  rsp_after_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i.valid |=> rsp_i.valid)
    else begin
      fail_count++;
      $error("no bus response one cycle after a request");
    end

  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !req_i.valid |=> !rsp_i.valid)
    else begin
      fail_count++;
      $error("bus response without a request in the cycle before");
    end

  err_rdata_zero: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (rsp_i.valid && rsp_i.err) |-> (rsp_i.rdata == '0))
    else begin
      fail_count++;
      $error("error response carries nonzero read data");
    end

  debug_held_off: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (cycles_q < DBG_DELAY_CYCLES) |-> !gated_debug_req_i)
    else begin
      fail_count++;
      $error("debug request passed during the hold-off window");
    end

endmodule

bind soc_lite_top soc_lite_assert i_assert (
  .clk_i             ( clk_i       ),
  .ndmreset_n        ( ndmreset_n  ),
  .req_i             ( bus_req_i   ),
  .rsp_i             ( bus_rsp_o   ),
  .gated_debug_req_i ( debug_req_o )
);

`default_nettype wire

// File: sim/tb_soc_lite.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_lite
  import soc_lite_pkg::*;
();

  logic               clk_i;
  logic               ndmreset_n;
  logic               rtc_i;
  bus_req_t           bus_req;
  bus_rsp_t           bus_rsp;
  logic               debug_req_i;
  logic               debug_req_o;
  logic               timer_irq_o;
  logic               ipi_o;
  logic [31:0]        lfsr;
  int unsigned        errors;
  logic [DATA_W-1:0]  rom_model [ROM_WORDS];
  logic [DATA_W-1:0]  msip_model;
  logic [MTIME_W-1:0] mtimecmp_model;
  logic [MTIME_W-1:0] mtime_model;

  soc_lite_top soc_lite_top_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .bus_req_i   ( bus_req     ),
    .bus_rsp_o   ( bus_rsp     ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      fail_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // a failed concurrent assertion ends the run as well
  always @(negedge clk_i) begin
    if (soc_lite_top_i.i_assert.fail_count != 0) begin
      fail_run("a concurrent assertion in soc_lite_assert failed");
    end
  end

  // ------------------------------------------------------------
  // single bus access with the response one cycle later
  // ------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
    bus_req_t    req;
    int unsigned waited;
    req.valid = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge clk_i);
    bus_req <= req;
    @(posedge clk_i);
    bus_req.valid <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > 8) begin
        fail_run($sformatf("timeout: no bus response for address 0x%0h", addr));
      end
    end while (!bus_rsp.valid);
    check_value("bus_rsp_o.valid latency", waited, 1);
    rdata = bus_rsp.rdata;
    err   = bus_rsp.err;
  endtask

  task automatic access_expect(input logic we, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               input logic [DATA_W-1:0] exp_rdata, input logic exp_err);
    logic [DATA_W-1:0] rdata;
    logic              err;
    bus_access(we, addr, wdata, rdata, err);
    check_value($sformatf("bus_rsp_o.err @0x%0h", addr), err, exp_err);
    check_value($sformatf("bus_rsp_o.rdata @0x%0h", addr), rdata, exp_rdata);
  endtask

  task automatic clint_write(input logic [15:0] ofs, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] rdata;
    logic              err;
    bus_access(1'b1, CLINT_BASE + ofs, wdata, rdata, err);
    check_value($sformatf("bus_rsp_o.err @clint+0x%0h", ofs), err, 1'b0);
  endtask

  // two rising rtc edges with each level held for five cycles
  task automatic rtc_pair();
    repeat (2) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (5) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (5) @(posedge clk_i);
    end
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] base;
    int unsigned       waited;
    lfsr           = 32'ha5b82a80;
    errors         = 0;
    ndmreset_n     = 1'b0;
    rtc_i          = 1'b0;
    bus_req        = '0;
    debug_req_i    = 1'b1;
    msip_model     = '0;
    mtimecmp_model = '1;
    mtime_model    = '0;
    $readmemh("rtl/soc_lite_bootrom.mem", rom_model);
    repeat (3) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    // debug request held off and then passed through
    for (int i = 0; i < DBG_DELAY_CYCLES; i++) begin
      @(negedge clk_i);
      check_value("debug_req_o", debug_req_o, 1'b0);
    end
    @(negedge clk_i);
    check_value("debug_req_o", debug_req_o, 1'b1);
    check_value("bus_rsp_o.valid", bus_rsp.valid, 1'b0);
    check_value("ipi_o", ipi_o, 1'b0);
    check_value("timer_irq_o", timer_irq_o, 1'b0);

    // ------------------------------------------------------------
    // rom reads and writes and the unmapped space
    // ------------------------------------------------------------
    repeat (20) begin
      addr = ROM_BASE + 4 * lfsr_bits(ROM_IDX_W);
      access_expect(1'b0, addr, '0, rom_model[(addr - ROM_BASE) / 4], 1'b0);
    end
    repeat (8) begin
      addr = ROM_BASE + 4 * lfsr_bits(ROM_IDX_W);
      access_expect(1'b1, addr, lfsr_bits(32), '0, 1'b1);
    end
    repeat (20) begin
      addr = lfsr_bits(32);
      data = lfsr_bits(1);
      if (!(addr >= ROM_BASE && addr < ROM_BASE + 4 * ROM_WORDS) &&
          !(addr >= CLINT_BASE && addr < CLINT_BASE + CLINT_LEN)) begin
        access_expect(data[0], addr, lfsr_bits(32), '0, 1'b1);
      end
    end
    // offsets between mtimecmp and mtime hold no register
    repeat (10) begin
      addr = CLINT_BASE + (32'h8000 | (4 * lfsr_bits(11)));
      access_expect(1'b0, addr, '0, '0, 1'b0);
    end

    // msip and mtimecmp read back
    repeat (10) begin
      msip_model = lfsr_bits(32);
      clint_write(MSIP_OFS, msip_model);
      check_value("ipi_o", ipi_o, msip_model[0]);
      access_expect(1'b0, CLINT_BASE + MSIP_OFS, '0, msip_model, 1'b0);
      mtimecmp_model = {lfsr_bits(32), lfsr_bits(32)};
      clint_write(MTIMECMP_LO_OFS, mtimecmp_model[31:0]);
      clint_write(MTIMECMP_HI_OFS, mtimecmp_model[63:32]);
      access_expect(1'b0, CLINT_BASE + MTIMECMP_LO_OFS, '0, mtimecmp_model[31:0], 1'b0);
      access_expect(1'b0, CLINT_BASE + MTIMECMP_HI_OFS, '0, mtimecmp_model[63:32], 1'b0);
    end

    // ------------------------------------------------------------
    // mtime ticks and timer interrupt
    // ------------------------------------------------------------
    base = lfsr_bits(16);
    mtime_model    = {32'h0, base};
    mtimecmp_model = {32'h0, base + 32'd3};
    clint_write(MTIME_HI_OFS, mtime_model[63:32]);
    clint_write(MTIME_LO_OFS, mtime_model[31:0]);
    clint_write(MTIMECMP_HI_OFS, mtimecmp_model[63:32]);
    clint_write(MTIMECMP_LO_OFS, mtimecmp_model[31:0]);
    access_expect(1'b0, CLINT_BASE + MTIME_HI_OFS, '0, mtime_model[63:32], 1'b0);
    access_expect(1'b0, CLINT_BASE + MTIME_LO_OFS, '0, mtime_model[31:0], 1'b0);
    check_value("timer_irq_o", timer_irq_o, 1'b0);
    repeat (4) begin
      rtc_pair();
      mtime_model = mtime_model + 1;
      access_expect(1'b0, CLINT_BASE + MTIME_LO_OFS, '0, mtime_model[31:0], 1'b0);
      check_value("timer_irq_o", timer_irq_o, mtime_model >= mtimecmp_model);
    end
    clint_write(MTIMECMP_LO_OFS, '1);
    clint_write(MTIMECMP_HI_OFS, '1);
    waited = 0;
    while (timer_irq_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > 4) begin
        fail_run("timeout: timer_irq_o stayed high after mtimecmp was set to all ones");
      end
    end

    // debug request follows the input after the window
    repeat (20) begin
      data = lfsr_bits(1);
      @(posedge clk_i);
      debug_req_i <= data[0];
      @(negedge clk_i);
      check_value("debug_req_o", debug_req_o, data[0]);
    end

    if (errors == 0 && soc_lite_top_i.i_assert.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1, "errors were counted");
    end
  end

endmodule

`default_nettype wire

// File: rtl/soc_lite_bootrom.mem
// boot rom image, one 32-bit hex word per line, word index 0 first
00000297
02028593
f1402573
0005a283
00028067
10500073
ffdff06f
00000013
deadbeef
0badc0de
13579bdf
2468ace0
c001d00d
8badf00d
55aa55aa
a5a5a5a5

// File: soc_lite.f
rtl/soc_lite_pkg.sv
rtl/soc_lite_bus_demux.sv
rtl/soc_lite_bootrom.sv
rtl/soc_lite_clint.sv
rtl/soc_lite_debug_gate.sv
rtl/soc_lite_top.sv
sim/soc_lite_assert.sv
sim/tb_soc_lite.sv

// File: Bender.yml
package:
  name: soc_lite

sources:
  - files:
      - rtl/soc_lite_pkg.sv
      - rtl/soc_lite_bus_demux.sv
      - rtl/soc_lite_bootrom.sv
      - rtl/soc_lite_clint.sv
      - rtl/soc_lite_debug_gate.sv
      - rtl/soc_lite_top.sv
  - target: simulation
    files:
      - sim/soc_lite_assert.sv
      - sim/tb_soc_lite.sv
